// File: logic/core_pkg.sv
package core_pkg;

  parameter int xlen = 32;                 // data path width.

  typedef logic [4:0] reg_addr_t;          // register index, x0 to x31.

  // operations the decoder can produce.
  typedef enum logic [3:0] {
    op_add,                                // r-type add.
    op_sub,                                // r-type sub.
    op_and,                                // r-type and.
    op_or,                                 // r-type or.
    op_xor,                                // r-type xor.
    op_addi,                               // i-type add.
    op_andi,                               // i-type and.
    op_ori,                                // i-type or.
    op_xori,                               // i-type xor.
    op_lui,                                // upper immediate load.
    op_beq,                                // branch if equal.
    op_bne,                                // branch if not equal.
    op_jal,                                // jump and link.
    op_illegal                             // anything else, runs as a no-op.
  } op_e;

  // decode to execute payload.
  typedef struct packed {
    op_e             op;                   // decoded operation.
    reg_addr_t       rd;                   // destination index.
    logic [xlen-1:0] rs1_val;              // first operand value.
    logic [xlen-1:0] rs2_val;              // second operand value.
    logic [xlen-1:0] imm;                  // sign extended immediate.
    logic [xlen-1:0] pc;                   // pc of this instruction.
  } dec_pkt_t;

  // execute to write-back payload.
  typedef struct packed {
    reg_addr_t       rd;                   // destination index.
    logic            we;                   // instruction writes rd.
    logic [xlen-1:0] result;               // value for rd.
    logic [xlen-1:0] next_pc;              // where fetch goes next.
    logic [xlen-1:0] pc;                   // pc of this instruction.
  } exe_pkt_t;

endpackage

// File: logic/bus_pkg.sv
package bus_pkg;

  // byte address width on the instruction read channel.
  parameter int addr_w = 32;

  // type used for the memory depth, counted in 32-bit words.
  typedef int unsigned depth_t;

endpackage

// File: logic/core_if.sv
`timescale 1ns/1ps

// instruction read channel, address phase then data phase.
interface axi_rd_if import bus_pkg::*; ();

  logic              arvalid;              // address valid.
  logic              arready;              // address accepted.
  logic [addr_w-1:0] araddr;               // byte address.
  logic              rvalid;               // data valid.
  logic              rready;               // data taken.
  logic [31:0]       rdata;                // instruction word.

  modport master (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata
  );

  modport slave (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata
  );

endinterface

// valid/ready link between two stages; the payload type is set per link.
interface stage_if #(parameter type payload_t = logic [63:0]) ();

  logic     valid;                         // producer holds data.
  logic     ready;                         // consumer can take it.
  payload_t data;                          // stage payload, pc included.

  modport master (
    output valid, data,
    input  ready
  );

  modport slave (
    input  valid, data,
    output ready
  );

endinterface

// File: logic/ifu.sv
`timescale 1ns/1ps

module ifu import core_pkg::*, bus_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            boot_i,          // first fetch starts at pc 0.
  input  logic            done_i,          // retire from wbu.
  input  logic [xlen-1:0] next_pc_i,       // pc after the retired instruction.
  axi_rd_if.master        bus,
  stage_if.master         out
);

  typedef enum logic [1:0] {
    st_idle         = 2'b00,
    st_wait_arready = 2'b01,
    st_wait_rvalid  = 2'b10,
    st_wait_ready   = 2'b11
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic [xlen-1:0] pc_q;                   // address of the fetch in flight.
  logic [31:0]     inst_q;                 // captured instruction word.
  logic            start;                  // kick from boot or retire.

  assign start = (boot_i || done_i) && (state_q == st_idle);

  assign bus.arvalid = (state_q == st_wait_arready);
  assign bus.araddr  = addr_w'(pc_q);     // pc only moves in idle.
  assign bus.rready  = (state_q == st_wait_rvalid);
  assign out.valid   = (state_q == st_wait_ready);
  assign out.data    = {pc_q, inst_q};     // pc in the upper half.

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:         if (start)       state_d = st_wait_arready;
      st_wait_arready: if (bus.arready) state_d = st_wait_rvalid;
      st_wait_rvalid:  if (bus.rvalid)  state_d = st_wait_ready;
      st_wait_ready:   if (out.ready)   state_d = st_idle;
      default:                          state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= st_idle;
      pc_q    <= '0;                       // boot fetches from address 0.
    end else begin
      state_q <= state_d;
      if (start && done_i) pc_q <= next_pc_i;  // redirect comes with retire.
    end
  end

  always_ff @(posedge clk) begin
    if (bus.rvalid && bus.rready) inst_q <= bus.rdata;  // hold until decode takes it.
  end

  // a retire that arrives during a fetch would be lost.
  a_done_in_idle: assert property (
    @(posedge clk) disable iff (!rst)
    done_i |-> state_q == st_idle
  );

endmodule

// File: logic/imem_axi.sv
`timescale 1ns/1ps

module imem_axi import bus_pkg::*; #(
  parameter depth_t      mem_words  = 256, // depth in words as a power of two.
  parameter int unsigned rd_latency = 2    // 1 to 15.
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prog_we_i,     // program load strobe.
  input  logic [addr_w-1:0] prog_addr_i,   // byte address of the word.
  input  logic [31:0]       prog_data_i,
  axi_rd_if.slave           bus
);

  localparam int idx_w = $clog2(mem_words);

  logic [31:0]      mem [mem_words];
  logic [3:0]       cnt_q;                 // cycles left until rvalid.
  logic [idx_w-1:0] idx_q;                 // word index of the accepted read.
  logic             rvalid_q;
  logic [31:0]      rdata_q;

  assign bus.arready = (cnt_q == '0) && !rvalid_q;  // one read at a time.
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt_q    <= '0;
      rvalid_q <= 1'b0;
      idx_q    <= '0;
    end else begin
      if (bus.arvalid && bus.arready) begin
        cnt_q <= 4'(rd_latency);           // counting starts at the accepting edge.
        idx_q <= bus.araddr[idx_w+1:2];
      end else if (cnt_q == 4'd1) begin
        cnt_q    <= '0;
        rvalid_q <= 1'b1;                  // rd_latency edges after acceptance.
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 4'd1;
      end
      if (rvalid_q && bus.rready) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (prog_we_i) mem[prog_addr_i[idx_w+1:2]] <= prog_data_i;
    if (cnt_q == 4'd1) rdata_q <= mem[idx_q];  // word loaded with rvalid.
  end

  // an address beyond the array or off a word boundary would alias to another word.
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (!rst)
    bus.arvalid && bus.arready |->
      (bus.araddr >> 2) < addr_w'(mem_words) && bus.araddr[1:0] == 2'b00
  );

endmodule

// File: logic/idu.sv
`timescale 1ns/1ps

module idu import core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  stage_if.slave          in,              // {pc, instruction} from fetch.
  stage_if.master         out,             // dec_pkt_t to execute.
  input  logic            wb_we_i,
  input  reg_addr_t       wb_rd_i,
  input  logic [xlen-1:0] wb_data_i
);

  logic [xlen-1:0] regs [32];              // register file.
  logic [xlen-1:0] pc;
  logic [31:0]     inst;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  reg_addr_t       rs1;
  reg_addr_t       rs2;
  op_e             dec_op;
  logic [xlen-1:0] dec_imm;
  dec_pkt_t        dec;
  dec_pkt_t        pkt_q;
  logic            valid_q;

  assign {pc, inst} = in.data;
  assign opcode     = inst[6:0];
  assign funct3     = inst[14:12];
  assign funct7     = inst[31:25];
  assign rs1        = inst[19:15];
  assign rs2        = inst[24:20];

  always_comb begin
    dec_op  = op_illegal;
    dec_imm = '0;
    case (opcode)
      7'b0110011: begin                    // register-register alu.
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  dec_op = op_add;
            3'b100:  dec_op = op_xor;
            3'b110:  dec_op = op_or;
            3'b111:  dec_op = op_and;
            default: dec_op = op_illegal;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec_op = op_sub;
        end
      end
      7'b0010011: begin                    // immediate alu.
        dec_imm = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          3'b000:  dec_op = op_addi;
          3'b100:  dec_op = op_xori;
          3'b110:  dec_op = op_ori;
          3'b111:  dec_op = op_andi;
          default: dec_op = op_illegal;
        endcase
      end
      7'b0110111: begin
        dec_op  = op_lui;
        dec_imm = {inst[31:12], 12'b0};
      end
      7'b1100011: begin                    // beq and bne only.
        dec_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (funct3 == 3'b000) dec_op = op_beq;
        else if (funct3 == 3'b001) dec_op = op_bne;
      end
      7'b1101111: begin
        dec_op  = op_jal;
        dec_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: dec_op = op_illegal;
    endcase
  end

  always_comb begin
    dec.op      = dec_op;
    dec.rd      = inst[11:7];
    dec.rs1_val = (rs1 == '0) ? '0 : regs[rs1];  // x0 reads zero.
    dec.rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    dec.imm     = dec_imm;
    dec.pc      = pc;
  end

  assign in.ready  = !valid_q;             // full output register stalls fetch.
  assign out.valid = valid_q;
  assign out.data  = pkt_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      valid_q <= 1'b0;
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else begin
      if (in.valid && in.ready) valid_q <= 1'b1;
      else if (out.ready) valid_q <= 1'b0;
      if (wb_we_i && wb_rd_i != '0) regs[wb_rd_i] <= wb_data_i;  // x0 stays 0.
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) pkt_q <= dec;
  end

endmodule

// File: logic/exu.sv
`timescale 1ns/1ps

module exu import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  stage_if.slave  in,                      // dec_pkt_t from decode.
  stage_if.master out                      // exe_pkt_t to write-back.
);

  dec_pkt_t        d;
  exe_pkt_t        res;
  exe_pkt_t        pkt_q;
  logic            valid_q;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;              // pc plus immediate.
  logic            eq;

  assign d         = in.data;
  assign pc_plus4  = d.pc + xlen'(4);
  assign pc_target = d.pc + d.imm;
  assign eq        = (d.rs1_val == d.rs2_val);

  always_comb begin
    res.rd      = d.rd;
    res.pc      = d.pc;
    res.we      = 1'b1;                    // cleared below for no-write ops.
    res.result  = '0;
    res.next_pc = pc_plus4;
    case (d.op)
      op_add:  res.result = d.rs1_val + d.rs2_val;
      op_sub:  res.result = d.rs1_val - d.rs2_val;
      op_and:  res.result = d.rs1_val & d.rs2_val;
      op_or:   res.result = d.rs1_val | d.rs2_val;
      op_xor:  res.result = d.rs1_val ^ d.rs2_val;
      op_addi: res.result = d.rs1_val + d.imm;
      op_andi: res.result = d.rs1_val & d.imm;
      op_ori:  res.result = d.rs1_val | d.imm;
      op_xori: res.result = d.rs1_val ^ d.imm;
      op_lui:  res.result = d.imm;
      op_beq: begin
        res.we = 1'b0;
        if (eq) res.next_pc = pc_target;
      end
      op_bne: begin
        res.we = 1'b0;
        if (!eq) res.next_pc = pc_target;
      end
      op_jal: begin
        res.result  = pc_plus4;            // link value.
        res.next_pc = pc_target;
      end
      default: res.we = 1'b0;              // illegal, falls through to pc+4.
    endcase
  end

  assign in.ready  = !valid_q;
  assign out.valid = valid_q;
  assign out.data  = pkt_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) valid_q <= 1'b0;
    else if (in.valid && in.ready) valid_q <= 1'b1;
    else if (out.ready) valid_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) pkt_q <= res;
  end

  // targets come from decoded immediates, fetch needs word addresses.
  a_next_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst)
    out.valid |-> pkt_q.next_pc[1:0] == 2'b00
  );

endmodule

// File: logic/wbu.sv
`timescale 1ns/1ps

module wbu import core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  stage_if.slave          in,              // exe_pkt_t from execute.
  output logic            wb_we_o,         // register write strobe.
  output reg_addr_t       wb_rd_o,
  output logic [xlen-1:0] wb_data_o,
  output logic            done_o,          // fetch may start again.
  output logic [xlen-1:0] next_pc_o,
  output logic            retire_o,
  output logic [xlen-1:0] retire_pc_o
);

  exe_pkt_t        e;
  logic            done_q;
  logic            we_q;
  reg_addr_t       rd_q;
  logic [xlen-1:0] data_q;
  logic [xlen-1:0] next_pc_q;
  logic [xlen-1:0] pc_q;

  assign e        = in.data;
  assign in.ready = !done_q;               // one packet per pulse.

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      done_q <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      done_q <= in.valid && in.ready;
      we_q   <= in.valid && in.ready && e.we && (e.rd != '0);  // no strobe for x0.
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      rd_q      <= e.rd;
      data_q    <= e.result;
      next_pc_q <= e.next_pc;
      pc_q      <= e.pc;
    end
  end

  assign wb_we_o     = we_q;
  assign wb_rd_o     = rd_q;
  assign wb_data_o   = data_q;
  assign done_o      = done_q;             // same cycle as the write strobe.
  assign next_pc_o   = next_pc_q;
  assign retire_o    = done_q;
  assign retire_pc_o = pc_q;

  // nothing may queue behind the retiring instruction.
  a_one_in_flight: assert property (
    @(posedge clk) disable iff (!rst)
    done_o |-> !in.valid
  );

endmodule

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*, bus_pkg::*; #(
  parameter depth_t      mem_words  = 256,
  parameter int unsigned rd_latency = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prog_we_i,     // instruction memory load.
  input  logic [addr_w-1:0] prog_addr_i,
  input  logic [xlen-1:0]   prog_data_i,
  input  logic              boot_i,        // starts the first fetch.
  output logic              retire_o,
  output logic [xlen-1:0]   retire_pc_o,
  output logic              rd_we_o,       // write-back strobe.
  output reg_addr_t         rd_addr_o,
  output logic [xlen-1:0]   rd_data_o
);

  logic            wb_we;
  reg_addr_t       wb_rd;
  logic [xlen-1:0] wb_data;
  logic            done;
  logic [xlen-1:0] next_pc;

  axi_rd_if                              ibus ();
  stage_if #(.payload_t(logic [63:0]))   if2id ();
  stage_if #(.payload_t(dec_pkt_t))      id2ex ();
  stage_if #(.payload_t(exe_pkt_t))      ex2wb ();

  imem_axi #(
    .mem_words  (mem_words),
    .rd_latency (rd_latency)
  ) u_imem (
    .clk         (clk),
    .rst         (rst),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .bus         (ibus.slave)
  );

  ifu u_ifu (
    .clk       (clk),
    .rst       (rst),
    .boot_i    (boot_i),
    .done_i    (done),
    .next_pc_i (next_pc),
    .bus       (ibus.master),
    .out       (if2id.master)
  );

  idu u_idu (
    .clk       (clk),
    .rst       (rst),
    .in        (if2id.slave),
    .out       (id2ex.master),
    .wb_we_i   (wb_we),
    .wb_rd_i   (wb_rd),
    .wb_data_i (wb_data)
  );

  exu u_exu (
    .clk (clk),
    .rst (rst),
    .in  (id2ex.slave),
    .out (ex2wb.master)
  );

  wbu u_wbu (
    .clk         (clk),
    .rst         (rst),
    .in          (ex2wb.slave),
    .wb_we_o     (wb_we),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data),
    .done_o      (done),
    .next_pc_o   (next_pc),
    .retire_o    (retire_o),
    .retire_pc_o (retire_pc_o)
  );

  assign rd_we_o   = wb_we;                // write-back seen from outside.
  assign rd_addr_o = wb_rd;
  assign rd_data_o = wb_data;

endmodule

// File: testbench/tb_ref.svh
`ifndef tb_ref_svh
`define tb_ref_svh

logic [31:0] ref_regs [32];                // architectural registers of the model.
logic [31:0] ref_pc;                       // pc of the next instruction to retire.

// executes one instruction on the model state and reports its register write.
function automatic void ref_step(
  input  logic [31:0] inst,
  output logic        we,
  output reg_addr_t   rd,
  output logic [31:0] data
);
  logic [6:0]  opcode;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] next_pc;
  logic        writes;
  opcode  = inst[6:0];
  f3      = inst[14:12];
  f7      = inst[31:25];
  rd      = inst[11:7];
  a       = ref_regs[inst[19:15]];          // x0 entry is never written.
  b       = ref_regs[inst[24:20]];
  imm_i   = {{20{inst[31]}}, inst[31:20]};
  imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  writes  = 1'b0;
  data    = '0;
  next_pc = ref_pc + 32'd4;
  case (opcode)
    7'b0110011: begin
      writes = 1'b1;
      case ({f7, f3})
        {7'h00, 3'h0}: data = a + b;
        {7'h20, 3'h0}: data = a - b;
        {7'h00, 3'h4}: data = a ^ b;
        {7'h00, 3'h6}: data = a | b;
        {7'h00, 3'h7}: data = a & b;
        default:       writes = 1'b0;      // not in the subset.
      endcase
    end
    7'b0010011: begin
      writes = 1'b1;
      case (f3)
        3'h0:    data = a + imm_i;
        3'h4:    data = a ^ imm_i;
        3'h6:    data = a | imm_i;
        3'h7:    data = a & imm_i;
        default: writes = 1'b0;
      endcase
    end
    7'b0110111: begin
      writes = 1'b1;
      data   = {inst[31:12], 12'b0};
    end
    7'b1100011: begin
      if ((f3 == 3'h0 && a == b) || (f3 == 3'h1 && a != b)) next_pc = ref_pc + imm_b;
    end
    7'b1101111: begin
      writes  = 1'b1;
      data    = ref_pc + 32'd4;            // link value.
      next_pc = ref_pc + imm_j;
    end
    default: writes = 1'b0;
  endcase
  we = writes && (rd != 5'd0);             // x0 writes are dropped.
  if (we) ref_regs[rd] = data;
  ref_pc = next_pc;
endfunction

`endif

// File: testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*, bus_pkg::*;;

  localparam int n_inst       = 48;        // program length in words.
  localparam int retire_limit = 200;       // cycles allowed between retires.
  localparam int run_limit    = 20000;

  logic              clk;
  logic              rst;
  logic              prog_we_i;
  logic [addr_w-1:0] prog_addr_i;
  logic [xlen-1:0]   prog_data_i;
  logic              boot_i;
  logic              retire_o;
  logic [xlen-1:0]   retire_pc_o;
  logic              rd_we_o;
  reg_addr_t         rd_addr_o;
  logic [xlen-1:0]   rd_data_o;

  logic [31:0] prog [n_inst];
  integer      seed;
  int          errors;
  int          checks;
  int          retired;
  logic        booted;
  logic        run_done;
  logic        timed_out;

  `include "tb_ref.svh"

  core_top #(
    .mem_words  (256),
    .rd_latency (3)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .boot_i      (boot_i),
    .retire_o    (retire_o),
    .retire_pc_o (retire_pc_o),
    .rd_we_o     (rd_we_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_o   (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // random program whose branches and jumps only go forward and whose last word jumps to itself.
  task automatic gen_program();
    int unsigned kind;
    int unsigned sel;
    int unsigned tgt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    for (int i = 0; i < n_inst - 1; i++) begin
      kind = $unsigned($random(seed)) % 7;
      sel  = $unsigned($random(seed)) % 5;
      rd   = 5'($unsigned($random(seed)) % 8);  // x0 comes up often.
      rs1  = 5'($unsigned($random(seed)) % 8);
      rs2  = 5'($unsigned($random(seed)) % 8);
      imm  = $random(seed);
      tgt  = i + 1 + ($unsigned($random(seed)) % 4);
      if (tgt > n_inst - 1) tgt = n_inst - 1;
      case (kind)
        0, 1: begin
          case (sel)
            0: prog[i] = {7'h00, rs2, rs1, 3'h0, rd, 7'b0110011};
            1: prog[i] = {7'h20, rs2, rs1, 3'h0, rd, 7'b0110011};
            2: prog[i] = {7'h00, rs2, rs1, 3'h4, rd, 7'b0110011};
            3: prog[i] = {7'h00, rs2, rs1, 3'h6, rd, 7'b0110011};
            default: prog[i] = {7'h00, rs2, rs1, 3'h7, rd, 7'b0110011};
          endcase
        end
        2, 3: begin
          case (sel % 4)
            0: prog[i] = {imm[11:0], rs1, 3'h0, rd, 7'b0010011};
            1: prog[i] = {imm[11:0], rs1, 3'h4, rd, 7'b0010011};
            2: prog[i] = {imm[11:0], rs1, 3'h6, rd, 7'b0010011};
            default: prog[i] = {imm[11:0], rs1, 3'h7, rd, 7'b0010011};
          endcase
        end
        4: prog[i] = {imm[31:12], rd, 7'b0110111};
        5: prog[i] = enc_b(13'((tgt - i) * 4), rs1 % 5'd4, rs2 % 5'd4,
                           3'(sel % 2));   // low regs tie often.
        default: prog[i] = enc_j(21'((tgt - i) * 4), rd);
      endcase
    end
    prog[n_inst-1] = enc_j(21'd0, 5'd0);   // self-loop.
  endtask

  task automatic load_program();
    for (int i = 0; i < n_inst; i++) begin
      @(posedge clk);
      #1;
      prog_we_i   = 1'b1;
      prog_addr_i = addr_w'(i * 4);
      prog_data_i = prog[i];
    end
    @(posedge clk);
    #1 prog_we_i = 1'b0;
  endtask

  initial begin : main
    int cyc;
    rst         = 1'b0;
    prog_we_i   = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    boot_i      = 1'b0;
    seed        = 32'h5400ddf5;
    errors      = 0;
    checks      = 0;
    retired     = 0;
    booted      = 1'b0;
    run_done    = 1'b0;
    timed_out   = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b1;
    gen_program();
    load_program();
    repeat (20) begin                      // core must stay quiet without boot.
      @(negedge clk);
      checks++;
      assert (!retire_o && !rd_we_o) else begin
        errors++;
        $display("ERR %0t: activity before boot, retire=%b rd_we=%b", $time, retire_o, rd_we_o);
      end
    end
    @(posedge clk);
    #1;
    boot_i = 1'b1;
    booted = 1'b1;
    @(posedge clk);
    #1 boot_i = 1'b0;
    cyc = 0;
    while (!run_done && !timed_out && cyc < run_limit) begin
      @(negedge clk);
      cyc++;
    end
    if (!run_done && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: program did not reach its final loop in %0d cycles", run_limit);
    end
    $display("retired %0d, checks %0d, errors %0d", retired, checks, errors);
    if (errors == 0 && !timed_out) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

  initial begin : compare
    logic        exp_we;
    reg_addr_t   exp_rd;
    logic [31:0] exp_data;
    logic [31:0] exp_pc;
    int          wait_cnt;
    int          loop_seen;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    ref_pc    = '0;
    loop_seen = 0;
    wait_cnt  = 0;
    while (!booted && wait_cnt < run_limit) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!booted) begin
      timed_out = 1'b1;
      $display("timeout: boot was never issued");
    end
    while (booted && !run_done && !timed_out) begin
      wait_cnt = 0;
      @(negedge clk);
      while (!retire_o && wait_cnt < retire_limit) begin
        checks++;
        assert (!rd_we_o) else begin
          errors++;
          $display("ERR %0t: register write without retire", $time);
        end
        @(negedge clk);
        wait_cnt++;
      end
      if (!retire_o) begin
        timed_out = 1'b1;
        $display("timeout: no retire within %0d cycles, model pc %h", retire_limit, ref_pc);
      end else begin
        retired++;
        exp_pc = ref_pc;
        ref_step(prog[ref_pc[31:2]], exp_we, exp_rd, exp_data);
        checks++;
        assert (retire_pc_o == exp_pc) else begin
          errors++;
          $display("ERR %0t: retire pc %h, expected %h", $time, retire_pc_o, exp_pc);
        end
        checks++;
        assert (rd_we_o == exp_we) else begin
          errors++;
          $display("ERR %0t: pc %h write enable %b, expected %b", $time, exp_pc, rd_we_o, exp_we);
        end
        if (exp_we) begin
          checks++;
          assert (rd_addr_o == exp_rd && rd_data_o == exp_data) else begin
            errors++;
            $display("ERR %0t: pc %h wrote x%0d=%h, expected x%0d=%h", $time, exp_pc,
                     rd_addr_o, rd_data_o, exp_rd, exp_data);
          end
        end
        if (exp_pc == 32'((n_inst - 1) * 4)) loop_seen++;
        if (loop_seen == 3) run_done = 1'b1;  // final self-loop retired a few times.
      end
    end
  end

endmodule

// File: vlog.f
+incdir+testbench
logic/core_pkg.sv
logic/bus_pkg.sv
logic/core_if.sv
logic/ifu.sv
logic/imem_axi.sv
logic/idu.sv
logic/exu.sv
logic/wbu.sv
logic/core_top.sv
testbench/tb_core.sv
